// ==== verilog/z2_pkg.sv ====
package z2_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // host bus widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int ADDR_W = 24;
  localparam int DATA_W = 16;

  // word address of the largest card, 2MB of 16-bit words
  localparam int WADDR_W = 20;

  typedef logic [ADDR_W-1:0] zorro_addr_t;
  typedef logic [DATA_W-1:0] zorro_data_t;

  // bit 1 follows uds, bit 0 follows lds
  typedef logic [1:0] byte_en_t;

  ////////////////////////////////////////////////////////////////////////////
  // address map
  ////////////////////////////////////////////////////////////////////////////

  localparam zorro_addr_t RAM_BASE    = 24'h600000;
  localparam zorro_addr_t CONFIG_BASE = 24'he80000;
  localparam int          CONFIG_SIZE = 256;

  ////////////////////////////////////////////////////////////////////////////
  // pending write, as held in the write queue
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [WADDR_W-1:0] word_addr;
    byte_en_t           byte_en;
    zorro_data_t        data;
  } wq_entry_t;

endpackage

// ==== verilog/zorro_bus_if.sv ====
`timescale 1ns/1ns

interface zorro_bus_if import z2_pkg::*; ();

  logic        as_n;
  // [1] is the older sample, [0] the newer one
  logic [1:0]  uds_n;
  logic [1:0]  lds_n;
  logic        read;
  zorro_addr_t addr;
  zorro_data_t data;

  modport sync_side (
    output as_n, uds_n, lds_n, read, addr, data
  );

  modport slave_side (
    input as_n, uds_n, lds_n, read, addr, data
  );

endinterface

// ==== verilog/mem_read_if.sv ====
`timescale 1ns/1ns

interface mem_read_if import z2_pkg::*; ();

  logic               rd_req;
  logic [WADDR_W-1:0] rd_addr;
  zorro_data_t        rd_data;
  // one cycle after rd_req, no back-pressure
  logic               rd_valid;

  modport requester (
    output rd_req, rd_addr,
    input  rd_data, rd_valid
  );

  modport responder (
    input  rd_req, rd_addr,
    output rd_data, rd_valid
  );

endinterface

// ==== verilog/zorro_sync.sv ====
`timescale 1ns/1ns

module zorro_sync import z2_pkg::*; (
  input  logic        vga_clk,
  input  logic        rst_n,
  input  logic        as_n,
  input  logic        uds_n,
  input  logic        lds_n,
  input  logic        read,
  input  zorro_addr_t addr,
  input  zorro_data_t data_in,
  zorro_bus_if.sync_side bus
);

  logic [1:0]  as_sync;
  logic [1:0]  read_sync;
  // three deep so the slave can compare two settled samples
  logic [2:0]  uds_hist;
  logic [2:0]  lds_hist;
  zorro_addr_t addr_q1, addr_q2;
  zorro_data_t data_q1, data_q2;

  always_ff @(posedge vga_clk or negedge rst_n) begin
    if (!rst_n) begin
      as_sync   <= 2'b11;
      read_sync <= 2'b11;
      uds_hist  <= 3'b111;
      lds_hist  <= 3'b111;
    end else begin
      as_sync   <= {as_sync[0], as_n};
      read_sync <= {read_sync[0], read};
      uds_hist  <= {uds_hist[1:0], uds_n};
      lds_hist  <= {lds_hist[1:0], lds_n};
    end
  end

  // address and data follow the same two-stage delay as the strobes
  always_ff @(posedge vga_clk) begin
    addr_q1 <= addr;
    addr_q2 <= addr_q1;
    data_q1 <= data_in;
    data_q2 <= data_q1;
  end

  assign bus.as_n  = as_sync[1];
  assign bus.read  = read_sync[1];
  assign bus.uds_n = uds_hist[2:1];
  assign bus.lds_n = lds_hist[2:1];
  assign bus.addr  = addr_q2;
  assign bus.data  = data_q2;

endmodule

// ==== verilog/autoconfig_rom.sv ====
`timescale 1ns/1ns

module autoconfig_rom import z2_pkg::*; (
  input  logic [7:0]  offset,
  output zorro_data_t nibble_word
);

  logic [3:0] nibble;

  always_comb begin
    case (offset)
      // zorro II board type
      8'h00:   nibble = 4'b1100;
      // size field, not chained
      8'h02:   nibble = 4'b0111;
      // product number
      8'h04:   nibble = 4'b0001;
      8'h06:   nibble = 4'b0111;
      // flags
      8'h08:   nibble = 4'b0100;
      // manufacturer, high then low byte
      8'h10:   nibble = 4'b0110;
      8'h12:   nibble = 4'b1101;
      8'h14:   nibble = 4'b0110;
      8'h16:   nibble = 4'b1101;
      default: nibble = 4'b0000;
    endcase
  end

  // host reads the nibble on d15..d12
  assign nibble_word = {nibble, 12'h000};

endmodule

// ==== verilog/zorro_slave.sv ====
`timescale 1ns/1ns

module zorro_slave import z2_pkg::*; #(
  parameter int RAM_WORDS = 4096
) (
  input  logic        vga_clk,
  input  logic        rst_n,
  input  logic        cfgin_n,
  zorro_bus_if.slave_side bus,
  mem_read_if.requester   rd,
  input  logic        full,
  input  logic        empty,
  output logic        push,
  output wq_entry_t   push_entry,
  output zorro_data_t data_out,
  output logic        data_oe,
  output logic        dir,
  output logic        slave_n
);

  localparam zorro_addr_t RAM_END    = RAM_BASE + ADDR_W'(2 * RAM_WORDS);
  localparam zorro_addr_t CONFIG_END = CONFIG_BASE + ADDR_W'(CONFIG_SIZE);

  typedef enum logic [2:0] {
    S_IDLE,
    S_READ_WAIT,
    S_READ_RETURN,
    S_ROM_READ,
    S_WRITE_WAIT,
    S_WRITE_DONE
  } state_t;

  state_t             state;
  logic               ram_hit;
  logic               cfg_hit;
  zorro_addr_t        ram_offset;
  logic [WADDR_W-1:0] cyc_word;
  logic               strobe_stable;
  byte_en_t           strobe_be;
  zorro_data_t        rom_word;

  ////////////////////////////////////////////////////////////////////////////
  // decode
  ////////////////////////////////////////////////////////////////////////////

  assign ram_hit    = (bus.addr >= RAM_BASE) && (bus.addr < RAM_END);
  assign cfg_hit    = (bus.addr >= CONFIG_BASE) && (bus.addr < CONFIG_END) && !cfgin_n;
  assign ram_offset = bus.addr - RAM_BASE;

  // both strobes unchanged over two samples, at least one asserted
  assign strobe_stable = (bus.uds_n[1] == bus.uds_n[0]) &&
                         (bus.lds_n[1] == bus.lds_n[0]) &&
                         (!bus.uds_n[1] || !bus.lds_n[1]);
  assign strobe_be     = {~bus.uds_n[1], ~bus.lds_n[1]};

  autoconfig_rom u_rom (
    .offset      (bus.addr[7:0]),
    .nibble_word (rom_word)
  );

  assign dir = ~data_oe;

  ////////////////////////////////////////////////////////////////////////////
  // bus cycle FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge vga_clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= S_IDLE;
      slave_n  <= 1'b1;
      data_oe  <= 1'b0;
      data_out <= '0;
      push     <= 1'b0;
      rd.rd_req <= 1'b0;
    end else begin
      // strobes last a single cycle
      push      <= 1'b0;
      rd.rd_req <= 1'b0;
      case (state)
        S_IDLE: begin
          if (!bus.as_n) begin
            cyc_word <= ram_offset[WADDR_W:1];
            if (bus.read && cfg_hit) begin
              data_out <= rom_word;
              slave_n  <= 1'b0;
              data_oe  <= 1'b1;
              state    <= S_ROM_READ;
            end else if (bus.read && ram_hit) begin
              state <= S_READ_WAIT;
            end else if (!bus.read && ram_hit) begin
              state <= S_WRITE_WAIT;
            end
          end
        end
        S_ROM_READ: begin
          if (bus.as_n) begin
            slave_n <= 1'b1;
            data_oe <= 1'b0;
            state   <= S_IDLE;
          end
        end
        // older writes must land before the read
        S_READ_WAIT: begin
          if (bus.as_n) begin
            state <= S_IDLE;
          end else if (empty) begin
            rd.rd_req <= 1'b1;
            state     <= S_READ_RETURN;
          end
        end
        S_READ_RETURN: begin
          if (rd.rd_valid) begin
            data_out <= rd.rd_data;
            slave_n  <= 1'b0;
            data_oe  <= 1'b1;
          end else if (!slave_n && bus.as_n) begin
            slave_n <= 1'b1;
            data_oe <= 1'b0;
            state   <= S_IDLE;
          end
        end
        // hold here while the queue is full
        S_WRITE_WAIT: begin
          if (bus.as_n) begin
            state <= S_IDLE;
          end else if (strobe_stable && !full) begin
            push    <= 1'b1;
            slave_n <= 1'b0;
            state   <= S_WRITE_DONE;
          end
        end
        S_WRITE_DONE: begin
          if (bus.as_n) begin
            slave_n <= 1'b1;
            state   <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // payload registers
  always_ff @(posedge vga_clk) begin
    if (state == S_WRITE_WAIT && strobe_stable) begin
      push_entry <= '{word_addr: cyc_word, byte_en: strobe_be, data: bus.data};
    end
    if (state == S_READ_WAIT) begin
      rd.rd_addr <= cyc_word;
    end
  end

endmodule

// ==== verilog/write_queue.sv ====
`timescale 1ns/1ns

module write_queue import z2_pkg::*; #(
  parameter int QUEUE_DEPTH = 16
) (
  input  logic      vga_clk,
  input  logic      rst_n,
  input  logic      push,
  input  wq_entry_t push_entry,
  input  logic      pop,
  output wq_entry_t head,
  output logic      full,
  output logic      empty
);

  localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  wq_entry_t        entries [QUEUE_DEPTH];
  logic [PTR_W-1:0] fill_ptr;
  logic [PTR_W-1:0] drain_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  always_ff @(posedge vga_clk or negedge rst_n) begin
    if (!rst_n) begin
      fill_ptr  <= '0;
      drain_ptr <= '0;
      count     <= '0;
    end else begin
      if (do_push) begin
        fill_ptr <= (fill_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : fill_ptr + 1'b1;
      end
      if (do_pop) begin
        drain_ptr <= (drain_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : drain_ptr + 1'b1;
      end
      // occupancy
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge vga_clk) begin
    if (do_push) begin
      entries[fill_ptr] <= push_entry;
    end
  end

  assign head  = entries[drain_ptr];
  assign full  = (count == CNT_W'(QUEUE_DEPTH));
  assign empty = (count == '0);

endmodule

// ==== verilog/card_memory.sv ====
`timescale 1ns/1ns

module card_memory import z2_pkg::*; #(
  parameter int RAM_WORDS = 4096
) (
  input  logic      vga_clk,
  input  logic      rst_n,
  mem_read_if.responder rd,
  input  wq_entry_t head,
  input  logic      empty,
  output logic      pop
);

  localparam int IDX_W = $clog2(RAM_WORDS);

  logic [DATA_W-1:0] mem [RAM_WORDS];
  logic [IDX_W-1:0]  wr_idx;
  logic [IDX_W-1:0]  rd_idx;

  assign wr_idx = head.word_addr[IDX_W-1:0];
  assign rd_idx = rd.rd_addr[IDX_W-1:0];

  // a read takes the cycle, the drain waits
  assign pop = !empty && !rd.rd_req;

  ////////////////////////////////////////////////////////////////////////////
  // storage, one write enable per byte lane
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge vga_clk) begin
    if (pop) begin
      if (head.byte_en[1]) begin
        mem[wr_idx][15:8] <= head.data[15:8];
      end
      if (head.byte_en[0]) begin
        mem[wr_idx][7:0] <= head.data[7:0];
      end
    end
    if (rd.rd_req) begin
      rd.rd_data <= mem[rd_idx];
    end
  end

  // data is valid exactly one cycle after the request
  always_ff @(posedge vga_clk or negedge rst_n) begin
    if (!rst_n) begin
      rd.rd_valid <= 1'b0;
    end else begin
      rd.rd_valid <= rd.rd_req;
    end
  end

endmodule

// ==== verilog/z2_card.sv ====
`timescale 1ns/1ns

module z2_card import z2_pkg::*; #(
  parameter int RAM_WORDS   = 4096,
  parameter int QUEUE_DEPTH = 16
) (
  input  logic        vga_clk,
  input  logic        rst_n,
  input  logic        cfgin_n,
  input  logic        as_n,
  input  logic        uds_n,
  input  logic        lds_n,
  input  logic        read,
  input  zorro_addr_t addr,
  input  zorro_data_t data_in,
  output zorro_data_t data_out,
  output logic        data_oe,
  output logic        dir,
  output logic        slave_n
);

  zorro_bus_if bus_if ();
  mem_read_if  rd_if ();

  logic      push;
  logic      pop;
  logic      full;
  logic      empty;
  wq_entry_t push_entry;
  wq_entry_t head;

  // host side
  zorro_sync u_sync (
    .vga_clk (vga_clk),
    .rst_n   (rst_n),
    .as_n    (as_n),
    .uds_n   (uds_n),
    .lds_n   (lds_n),
    .read    (read),
    .addr    (addr),
    .data_in (data_in),
    .bus     (bus_if.sync_side)
  );

  zorro_slave #(
    .RAM_WORDS (RAM_WORDS)
  ) u_slave (
    .vga_clk    (vga_clk),
    .rst_n      (rst_n),
    .cfgin_n    (cfgin_n),
    .bus        (bus_if.slave_side),
    .rd         (rd_if.requester),
    .full       (full),
    .empty      (empty),
    .push       (push),
    .push_entry (push_entry),
    .data_out   (data_out),
    .data_oe    (data_oe),
    .dir        (dir),
    .slave_n    (slave_n)
  );

  // write path into card memory
  write_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) u_queue (
    .vga_clk    (vga_clk),
    .rst_n      (rst_n),
    .push       (push),
    .push_entry (push_entry),
    .pop        (pop),
    .head       (head),
    .full       (full),
    .empty      (empty)
  );

  card_memory #(
    .RAM_WORDS (RAM_WORDS)
  ) u_mem (
    .vga_clk (vga_clk),
    .rst_n   (rst_n),
    .rd      (rd_if.responder),
    .head    (head),
    .empty   (empty),
    .pop     (pop)
  );

endmodule

// ==== testbench/z2_checker.sv ====
`timescale 1ns/1ns

module z2_checker import z2_pkg::*; (
  input  logic        vga_clk,
  input  logic        idle_check,
  input  logic        arm,
  input  logic        report,
  input  int          test_num,
  input  logic [7:0]  test_op,
  input  zorro_addr_t test_addr,
  input  logic        expect_answer,
  input  logic        compare_data,
  input  zorro_data_t exp_data,
  input  logic        slave_n,
  input  zorro_data_t data_out,
  input  logic        data_oe,
  input  logic        dir,
  output int          pass_count,
  output int          fail_count
);

  logic        arm_q;
  logic        answered;
  int          test_errors;
  zorro_data_t got_data;

  initial begin
    pass_count  = 0;
    fail_count  = 0;
    arm_q       = 1'b0;
    answered    = 1'b0;
    test_errors = 0;
    got_data    = '0;
  end

  task automatic close_test(input int errors);
    if (errors == 0) begin
      pass_count = pass_count + 1;
      $display("test %0d (%c %06h) ok", test_num, test_op, test_addr);
    end else begin
      fail_count = fail_count + 1;
      $display("test %0d (%c %06h) failed", test_num, test_op, test_addr);
    end
  endtask

  always @(posedge vga_clk) begin
    // reset values before the first bus cycle
    if (idle_check) begin
      test_errors = 0;
      if (slave_n !== 1'b1) begin
        $display("Mismatch slave_n: got 0x%0h expected 0x1", slave_n);
        test_errors = test_errors + 1;
      end
      if (data_oe !== 1'b0) begin
        $display("Mismatch data_oe: got 0x%0h expected 0x0", data_oe);
        test_errors = test_errors + 1;
      end
      if (dir !== 1'b1) begin
        $display("Mismatch dir: got 0x%0h expected 0x1", dir);
        test_errors = test_errors + 1;
      end
      close_test(test_errors);
    end

    if (arm && !arm_q) begin
      answered    = 1'b0;
      test_errors = 0;
    end
    // first cycle with slave_n low holds the answer
    if (arm && !answered && !slave_n) begin
      answered = 1'b1;
      got_data = data_out;
      if (data_oe !== compare_data) begin
        $display("Mismatch data_oe: got 0x%0h expected 0x%0h", data_oe, compare_data);
        test_errors = test_errors + 1;
      end
      // card drives the bus only while it returns read data
      if (dir !== !compare_data) begin
        $display("Mismatch dir: got 0x%0h expected 0x%0h", dir, !compare_data);
        test_errors = test_errors + 1;
      end
    end

    if (!arm && arm_q) begin
      if (expect_answer && !answered) begin
        $display("Test %0d got no answer from the card before the timeout", test_num);
        test_errors = test_errors + 1;
      end else if (!expect_answer && answered) begin
        $display("Test %0d was answered although the card should ignore it", test_num);
        test_errors = test_errors + 1;
      end else if (answered && compare_data && got_data !== exp_data) begin
        $display("Mismatch data_out: got 0x%04h expected 0x%04h", got_data, exp_data);
        test_errors = test_errors + 1;
      end
      if (slave_n !== 1'b1) begin
        $display("Test %0d left slave_n low after the address strobe was released",
                 test_num);
        test_errors = test_errors + 1;
      end
      if (data_oe !== 1'b0 || dir !== 1'b1) begin
        $display("Test %0d left the data bus driven after the address strobe was released",
                 test_num);
        test_errors = test_errors + 1;
      end
      close_test(test_errors);
    end
    arm_q = arm;

    if (report) begin
      $display("tests run %0d, passed %0d, failed %0d",
               pass_count + fail_count, pass_count, fail_count);
    end
  end

endmodule

// ==== testbench/tb_z2.sv ====
`timescale 1ns/1ns

module tb_z2 import z2_pkg::*; ();

  localparam int RAM_WORDS    = 4096;
  localparam int QUEUE_DEPTH  = 16;
  localparam int TIMEOUT      = 200;
  localparam int RESET_CYCLES = 5;

  logic        vga_clk;
  logic        rst_n;
  logic        cfgin_n;
  logic        as_n;
  logic        uds_n;
  logic        lds_n;
  logic        read;
  zorro_addr_t addr;
  zorro_data_t data_in;
  zorro_data_t data_out;
  logic        data_oe;
  logic        dir;
  logic        slave_n;

  // expectations handed to the checker
  logic        idle_check;
  logic        arm;
  logic        expect_answer;
  logic        compare_data;
  zorro_data_t exp_data;
  int          test_num;
  logic [7:0]  test_op;
  logic        report;
  int          pass_count;
  int          fail_count;
  int          trace_errors;

  z2_card #(
    .RAM_WORDS   (RAM_WORDS),
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) UUT (
    .vga_clk  (vga_clk),
    .rst_n    (rst_n),
    .cfgin_n  (cfgin_n),
    .as_n     (as_n),
    .uds_n    (uds_n),
    .lds_n    (lds_n),
    .read     (read),
    .addr     (addr),
    .data_in  (data_in),
    .data_out (data_out),
    .data_oe  (data_oe),
    .dir      (dir),
    .slave_n  (slave_n)
  );

  z2_checker u_checker (
    .vga_clk       (vga_clk),
    .idle_check    (idle_check),
    .arm           (arm),
    .report        (report),
    .test_num      (test_num),
    .test_op       (test_op),
    .test_addr     (addr),
    .expect_answer (expect_answer),
    .compare_data  (compare_data),
    .exp_data      (exp_data),
    .slave_n       (slave_n),
    .data_out      (data_out),
    .data_oe       (data_oe),
    .dir           (dir),
    .pass_count    (pass_count),
    .fail_count    (fail_count)
  );

  initial begin
    vga_clk = 1'b0;
    forever #5 vga_clk = ~vga_clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // bus cycle driver
  ////////////////////////////////////////////////////////////////////////////

  // rest of a comment line in the trace
  task automatic skip_line(input int fd);
    int ch;
    ch = $fgetc(fd);
    while (ch != 8'h0a && ch != -1) begin
      ch = $fgetc(fd);
    end
  endtask

  // strb[1] is uds, strb[0] is lds, 1 means asserted
  task automatic run_bus_cycle(input logic [7:0] op, input zorro_addr_t a,
                               input logic [1:0] strb, input zorro_data_t wdata,
                               input zorro_data_t expv);
    int waited;
    @(negedge vga_clk);
    test_num      = test_num + 1;
    test_op       = op;
    expect_answer = (op == "c" || op == "r" || op == "w");
    compare_data  = (op == "c" || op == "r");
    exp_data      = expv;
    // config chain is only open for config reads
    cfgin_n       = (op != "c");
    read          = !(op == "w" || op == "u");
    addr          = a;
    data_in       = wdata;
    as_n          = 1'b0;
    uds_n         = !strb[1];
    lds_n         = !strb[0];
    arm           = 1'b1;
    waited = 0;
    while (slave_n && waited < TIMEOUT) begin
      @(negedge vga_clk);
      waited = waited + 1;
    end
    as_n  = 1'b1;
    uds_n = 1'b1;
    lds_n = 1'b1;
    waited = 0;
    while (!slave_n && waited < TIMEOUT) begin
      @(negedge vga_clk);
      waited = waited + 1;
    end
    // let the synchronisers see the idle bus
    repeat (2) @(negedge vga_clk);
    arm = 1'b0;
  endtask

  initial begin : main
    int          fd;
    int          code;
    logic [7:0]  op;
    zorro_addr_t t_addr;
    logic [1:0]  strb;
    zorro_data_t wdata;
    zorro_data_t expv;
    cfgin_n       = 1'b1;
    as_n          = 1'b1;
    uds_n         = 1'b1;
    lds_n         = 1'b1;
    read          = 1'b1;
    addr          = '0;
    data_in       = '0;
    idle_check    = 1'b0;
    arm           = 1'b0;
    report        = 1'b0;
    expect_answer = 1'b0;
    compare_data  = 1'b0;
    exp_data      = '0;
    test_num      = 0;
    test_op       = "-";
    trace_errors  = 0;
    rst_n         = 1'b0;
    repeat (RESET_CYCLES) @(posedge vga_clk);
    @(negedge vga_clk);
    rst_n = 1'b1;

    // outputs idle before the first bus cycle
    @(negedge vga_clk);
    test_num   = 1;
    idle_check = 1'b1;
    @(negedge vga_clk);
    idle_check = 1'b0;

    fd = $fopen("testbench/z2_trace.txt", "r");
    if (fd == 0) begin
      $display("Could not open the trace file testbench/z2_trace.txt");
      trace_errors = trace_errors + 1;
    end else begin
      code = $fscanf(fd, " %c", op);
      while (code == 1) begin
        if (op == "#") begin
          skip_line(fd);
        end else begin
          code = $fscanf(fd, "%h %b %h %h", t_addr, strb, wdata, expv);
          if (code != 4) begin
            $display("The trace line after test %0d could not be read", test_num);
            trace_errors = trace_errors + 1;
          end else begin
            run_bus_cycle(op, t_addr, strb, wdata, expv);
          end
        end
        code = $fscanf(fd, " %c", op);
      end
      $fclose(fd);
    end
    if (test_num < 2) begin
      $display("The trace held no bus operations");
      trace_errors = trace_errors + 1;
    end

    @(negedge vga_clk);
    report = 1'b1;
    @(negedge vga_clk);
    report = 1'b0;
    if (fail_count == 0 && trace_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== z2_card.f ====
verilog/z2_pkg.sv
verilog/zorro_bus_if.sv
verilog/mem_read_if.sv
verilog/zorro_sync.sv
verilog/autoconfig_rom.sv
verilog/zorro_slave.sv
verilog/write_queue.sv
verilog/card_memory.sv
verilog/z2_card.sv
testbench/z2_checker.sv
testbench/tb_z2.sv

// ==== testbench/z2_trace.txt ====
# op address strobes(uds lds, 1 = asserted) write_data expected_read
# op: c config read, w write, r read, n read with no answer, u write with no answer
c e80000 11 0000 c000
c e80002 11 0000 7000
c e80004 11 0000 1000
c e80006 11 0000 7000
c e80008 11 0000 4000
c e8000a 11 0000 0000
c e80010 11 0000 6000
c e80012 11 0000 d000
c e80014 11 0000 6000
c e80016 11 0000 d000
c e8001a 11 0000 0000
c e80040 11 0000 0000
n e80000 11 0000 0000
w 600000 11 1234 0000
r 600000 11 0000 1234
w 600100 11 5a5a 0000
w 600100 10 abff 0000
r 600100 11 0000 ab5a
w 600100 01 00cd 0000
r 600100 11 0000 abcd
w 600200 11 a5c0 0000
w 600202 11 a5c1 0000
w 600204 11 a5c2 0000
w 600206 11 a5c3 0000
w 600208 11 a5c4 0000
w 60020a 11 a5c5 0000
w 60020c 11 a5c6 0000
w 60020e 11 a5c7 0000
w 600210 11 a5c8 0000
w 600212 11 a5c9 0000
w 600214 11 a5ca 0000
w 600216 11 a5cb 0000
w 600218 11 a5cc 0000
w 60021a 11 a5cd 0000
w 60021c 11 a5ce 0000
w 60021e 11 a5cf 0000
w 600220 11 a5d0 0000
r 600200 11 0000 a5c0
r 600202 11 0000 a5c1
r 600204 11 0000 a5c2
r 600206 11 0000 a5c3
r 600208 11 0000 a5c4
r 60020a 11 0000 a5c5
r 60020c 11 0000 a5c6
r 60020e 11 0000 a5c7
r 600210 11 0000 a5c8
r 600212 11 0000 a5c9
r 600214 11 0000 a5ca
r 600216 11 0000 a5cb
r 600218 11 0000 a5cc
r 60021a 11 0000 a5cd
r 60021c 11 0000 a5ce
r 60021e 11 0000 a5cf
r 600220 11 0000 a5d0
n 200000 11 0000 0000
u 200000 11 dead 0000
u 602000 11 beef 0000
n 602000 11 0000 0000
r 600000 11 0000 1234
r 600100 11 0000 abcd
